// ==== common/ctrl_board_defines.svh ====
// Timer defaults assume an 80 MHz board clock; FTW and DUTY bases must stay 4-byte aligned
`ifndef CTRL_BOARD_DEFINES_SVH
`define CTRL_BOARD_DEFINES_SVH

// ****************************************
// Widths
// ****************************************
`define CB_LBS_ADDR_W       12
`define CB_LBS_DATA_W       16
`define CB_REG_W            8
`define CB_PHASE_W          32

// ****************************************
// Register map
// ****************************************
`define CB_REG_BASE         12'h000     // Upper address nibble selects the register window
`define CB_ADDR_VERSION     8'h00
`define CB_ADDR_SCRATCH     8'h01
`define CB_ADDR_RELAY       8'h02
`define CB_ADDR_TTL_OUT     8'h03
`define CB_ADDR_TTL_IN      8'h04
`define CB_ADDR_LVTTL_IN    8'h05
`define CB_ADDR_INT_STATUS  8'h06
`define CB_ADDR_INT_MASK    8'h07
`define CB_ADDR_FTW0        8'h08       // Bytes 0x08..0x0B, LSB first
`define CB_ADDR_DUTY0       8'h0C       // Bytes 0x0C..0x0F, LSB first
`define CB_ADDR_PWM_CTRL    8'h10

// Constants and timer defaults
`define CB_VERSION          8'h17
`define CB_CLKS_PER_MS      80000
`define CB_RUN_HALF_MS      500

`endif

// ==== common/ctrl_board_pkg.sv ====
// Types shared by the control board RTL and testbench; widths come from the defines header
`include "ctrl_board_defines.svh"

package ctrl_board_pkg;

    // ****************************************
    // Vector types
    // ****************************************
    typedef logic [`CB_LBS_ADDR_W-1:0] lbs_addr_t;     // DSP local-bus address
    typedef logic [`CB_LBS_DATA_W-1:0] lbs_data_t;     // DSP local-bus data
    typedef logic [`CB_REG_W-1:0]      reg_addr_t;
    typedef logic [`CB_REG_W-1:0]      reg_data_t;
    typedef logic [`CB_PHASE_W-1:0]    phase_t;        // Accumulator, FTW and duty

    // Register access, one wr or rd pulse per bus access
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t wdata;
        logic      wr;
        logic      rd;
    } reg_req_t;

    // PWM configuration from the register block
    typedef struct packed {
        phase_t    ftw;
        phase_t    duty;
        logic      load;        // One-cycle shadow transfer
        logic      en;
    } pwm_cfg_t;

    // Local-bus access sequencer
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        HOLD
    } lbs_state_t;

endpackage

// ==== hw/lbs_ctrl.sv ====
// Assumes the DSP holds address and data stable for the whole chip-select low period, 6+ cycles
`timescale 1ns/1ps
`include "ctrl_board_defines.svh"

module lbs_ctrl
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  ctrl_board_pkg::lbs_addr_t   lbs_addr_i,
    input  ctrl_board_pkg::lbs_data_t   lbs_din_i,
    input  logic                        lbs_cs_n_i,
    input  logic                        lbs_we_i,
    input  logic                        lbs_re_i,
    input  ctrl_board_pkg::reg_data_t   rdata_i,
    output ctrl_board_pkg::reg_req_t    req_o,
    output ctrl_board_pkg::lbs_data_t   lbs_dout_o
);

localparam ctrl_board_pkg::lbs_addr_t REG_BASE = `CB_REG_BASE;

logic [2:0]                 strb_meta;      // {cs_n, we, re}
logic [2:0]                 strb_sync;
logic                       hit;
logic                       rd_q;           // Current access is a read
logic                       hit_q;
logic                       rd_done;
ctrl_board_pkg::reg_data_t  rdata_q;
ctrl_board_pkg::lbs_state_t state;

// Register window decode on the upper address bits
assign hit = (lbs_addr_i[`CB_LBS_ADDR_W-1:`CB_REG_W] == REG_BASE[`CB_LBS_ADDR_W-1:`CB_REG_W]);

always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
    begin
        strb_meta <= 3'b100;                // Chip select idles high
        strb_sync <= 3'b100;
    end
    else
    begin
        strb_meta <= {lbs_cs_n_i, lbs_we_i, lbs_re_i};
        strb_sync <= strb_meta;
    end
end

// ****************************************
// Access sequencer
// ****************************************
always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
    begin
        state <= ctrl_board_pkg::IDLE;
        req_o <= '0;
        rd_q  <= 1'b0;
        hit_q <= 1'b0;
    end
    else
    begin
        req_o.wr <= 1'b0;
        req_o.rd <= 1'b0;
        case (state)
            ctrl_board_pkg::IDLE:
            begin
                if (!strb_sync[2])
                begin
                    state       <= ctrl_board_pkg::ACCESS;
                    req_o.addr  <= lbs_addr_i[`CB_REG_W-1:0];
                    req_o.wdata <= lbs_din_i[`CB_REG_W-1:0];
                    req_o.wr    <= strb_sync[1] & hit;
                    req_o.rd    <= strb_sync[0] & ~strb_sync[1] & hit;  // Write wins
                    rd_q        <= strb_sync[0] & ~strb_sync[1];
                    hit_q       <= hit;
                end
            end
            ctrl_board_pkg::ACCESS: state <= ctrl_board_pkg::HOLD;
            ctrl_board_pkg::HOLD:
            begin
                if (strb_sync[2])           // Wait for chip select release
                    state <= ctrl_board_pkg::IDLE;
            end
            default: state <= ctrl_board_pkg::IDLE;
        endcase
    end
end

// Read data capture in ACCESS, then the pin register
always_ff @(posedge clk_i)
begin
    if (state == ctrl_board_pkg::ACCESS && rd_q)
        rdata_q <= hit_q ? rdata_i : '0;    // Outside the window reads zero
end

always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
    begin
        rd_done    <= 1'b0;
        lbs_dout_o <= '0;
    end
    else
    begin
        rd_done <= (state == ctrl_board_pkg::ACCESS) && rd_q;
        if (rd_done)
            lbs_dout_o <= {{(`CB_LBS_DATA_W-`CB_REG_W){1'b0}}, rdata_q};
    end
end

endmodule

// ==== hw/sys_registers.sv ====
// LVTTL interrupts latch on synchronized rising edges only; FTW and DUTY are unknown until written
`timescale 1ns/1ps
`include "ctrl_board_defines.svh"

module sys_registers
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  ctrl_board_pkg::reg_req_t    req_i,
    input  logic [5:0]                  f_ttl_i,
    input  logic [7:0]                  lvttl_i,
    output ctrl_board_pkg::reg_data_t   rdata_o,
    output logic [7:0]                  int_o,
    output logic [3:0]                  relay_con_o,
    output logic                        relay_oen_o,
    output logic [5:0]                  ttl_o,
    output logic                        ttl_en_o,
    output logic                        lvttl_en_o,
    output ctrl_board_pkg::pwm_cfg_t    pwm_cfg_o
);

localparam ctrl_board_pkg::reg_addr_t FTW_BASE  = `CB_ADDR_FTW0;
localparam ctrl_board_pkg::reg_addr_t DUTY_BASE = `CB_ADDR_DUTY0;

ctrl_board_pkg::reg_data_t  scratch_q;
ctrl_board_pkg::reg_data_t  int_status_q;
ctrl_board_pkg::reg_data_t  int_mask_q;
ctrl_board_pkg::phase_t     ftw_q;
ctrl_board_pkg::phase_t     duty_q;
logic                       pwm_en_q;
logic                       pwm_load_q;
logic [5:0]                 ttl_meta;
logic [5:0]                 ttl_sync;
logic [7:0]                 lvttl_meta;
logic [7:0]                 lvttl_sync;
logic [7:0]                 lvttl_prev;
logic                       ftw_sel;
logic                       duty_sel;

assign ftw_sel  = (req_i.addr[7:2] == FTW_BASE[7:2]);
assign duty_sel = (req_i.addr[7:2] == DUTY_BASE[7:2]);

// ****************************************
// Control registers
// ****************************************
always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
    begin
        scratch_q   <= '0;
        relay_con_o <= '0;
        relay_oen_o <= 1'b1;                // Relay buffer disabled
        ttl_o       <= '0;
        ttl_en_o    <= 1'b0;
        lvttl_en_o  <= 1'b0;
        int_mask_q  <= '0;
        pwm_en_q    <= 1'b0;
        pwm_load_q  <= 1'b0;
    end
    else
    begin
        pwm_load_q <= 1'b0;
        if (req_i.wr)
        begin
            case (req_i.addr)
                `CB_ADDR_SCRATCH:  scratch_q <= req_i.wdata;
                `CB_ADDR_RELAY:
                begin
                    relay_con_o <= req_i.wdata[3:0];
                    relay_oen_o <= req_i.wdata[7];
                end
                `CB_ADDR_TTL_OUT:
                begin
                    ttl_o      <= req_i.wdata[5:0];
                    lvttl_en_o <= req_i.wdata[6];
                    ttl_en_o   <= req_i.wdata[7];
                end
                `CB_ADDR_INT_MASK: int_mask_q <= req_i.wdata;
                `CB_ADDR_PWM_CTRL:
                begin
                    pwm_en_q   <= req_i.wdata[0];
                    pwm_load_q <= req_i.wdata[1];   // Self-clearing
                end
                default: ;
            endcase
        end
    end
end

// Phase words, little-endian bytes
always_ff @(posedge clk_i)
begin
    if (req_i.wr && ftw_sel)
        ftw_q[8*req_i.addr[1:0] +: 8] <= req_i.wdata;
    if (req_i.wr && duty_sel)
        duty_q[8*req_i.addr[1:0] +: 8] <= req_i.wdata;
end

// ****************************************
// Input sync and interrupt latch
// ****************************************
always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
    begin
        ttl_meta     <= '0;
        ttl_sync     <= '0;
        lvttl_meta   <= '0;
        lvttl_sync   <= '0;
        lvttl_prev   <= '0;
        int_status_q <= '0;
    end
    else
    begin
        ttl_meta   <= f_ttl_i;
        ttl_sync   <= ttl_meta;
        lvttl_meta <= lvttl_i;
        lvttl_sync <= lvttl_meta;
        lvttl_prev <= lvttl_sync;
        // A new edge beats a clear in the same cycle
        if (req_i.wr && req_i.addr == `CB_ADDR_INT_STATUS)
            int_status_q <= (int_status_q & ~req_i.wdata) | (lvttl_sync & ~lvttl_prev);
        else
            int_status_q <= int_status_q | (lvttl_sync & ~lvttl_prev);
    end
end

assign int_o = int_status_q & int_mask_q;

// Read mux
always_comb
begin
    rdata_o = '0;
    case (req_i.addr)
        `CB_ADDR_VERSION:    rdata_o = `CB_VERSION;
        `CB_ADDR_SCRATCH:    rdata_o = scratch_q;
        `CB_ADDR_RELAY:      rdata_o = {relay_oen_o, 3'b000, relay_con_o};
        `CB_ADDR_TTL_OUT:    rdata_o = {ttl_en_o, lvttl_en_o, ttl_o};
        `CB_ADDR_TTL_IN:     rdata_o = {2'b00, ttl_sync};
        `CB_ADDR_LVTTL_IN:   rdata_o = lvttl_sync;
        `CB_ADDR_INT_STATUS: rdata_o = int_status_q;
        `CB_ADDR_INT_MASK:   rdata_o = int_mask_q;
        `CB_ADDR_PWM_CTRL:   rdata_o = {7'b0000000, pwm_en_q};     // Load reads zero
        default:
        begin
            if (ftw_sel)
                rdata_o = ftw_q[8*req_i.addr[1:0] +: 8];
            else if (duty_sel)
                rdata_o = duty_q[8*req_i.addr[1:0] +: 8];
        end
    endcase
end

assign pwm_cfg_o.ftw  = ftw_q;
assign pwm_cfg_o.duty = duty_q;
assign pwm_cfg_o.load = pwm_load_q;
assign pwm_cfg_o.en   = pwm_en_q;

endmodule

// ==== hw/board_timer.sv ====
// Toggle interval is CLKS_PER_MS * RUN_HALF_MS clocks; both parameters must be at least 1
`timescale 1ns/1ps
`include "ctrl_board_defines.svh"

module board_timer #(
    parameter int CLKS_PER_MS = `CB_CLKS_PER_MS,
    parameter int RUN_HALF_MS = `CB_RUN_HALF_MS
)
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    output logic    run_o
);

localparam int CLK_CNT_W = $clog2(CLKS_PER_MS + 1);
localparam int MS_CNT_W  = $clog2(RUN_HALF_MS + 1);

logic [CLK_CNT_W-1:0]   clk_cnt;
logic [MS_CNT_W-1:0]    ms_cnt;
logic                   ms_tick;

// ****************************************
// Millisecond tick
// ****************************************
always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
    begin
        clk_cnt <= '0;
        ms_tick <= 1'b0;
    end
    else if (clk_cnt == CLK_CNT_W'(CLKS_PER_MS - 1))
    begin
        clk_cnt <= '0;
        ms_tick <= 1'b1;
    end
    else
    begin
        clk_cnt <= clk_cnt + 1'b1;
        ms_tick <= 1'b0;
    end
end

// Run indicator, one toggle per half period
always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
    begin
        ms_cnt <= '0;
        run_o  <= 1'b0;
    end
    else if (ms_tick)
    begin
        if (ms_cnt == MS_CNT_W'(RUN_HALF_MS - 1))
        begin
            ms_cnt <= '0;
            run_o  <= ~run_o;
        end
        else
            ms_cnt <= ms_cnt + 1'b1;
    end
end

endmodule

// ==== hw/pwm_ctrl.sv ====
// New FTW and duty act only after a load pulse; output duty is duty / 2^32 of each phase wrap
`timescale 1ns/1ps

module pwm_ctrl
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  ctrl_board_pkg::pwm_cfg_t    cfg_i,
    output logic                        pwm_o
);

ctrl_board_pkg::phase_t ftw_q;      // Active frequency word
ctrl_board_pkg::phase_t duty_q;     // Active duty threshold
ctrl_board_pkg::phase_t acc;

// ****************************************
// Shadow transfer and phase accumulator
// ****************************************
always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
    begin
        ftw_q  <= '0;
        duty_q <= '0;
        acc    <= '0;
    end
    else if (cfg_i.load)
    begin
        ftw_q  <= cfg_i.ftw;
        duty_q <= cfg_i.duty;
        acc    <= '0;                   // Restart the period
    end
    else if (cfg_i.en)
        acc <= acc + ftw_q;             // Wraps at 2^32
    else
        acc <= '0;
end

// High for the first part of each period
assign pwm_o = cfg_i.en & (acc < duty_q);

endmodule

// ==== hw/control_board.sv ====
// Single board clock domain; local bus uses split read/write data and has no wait signal
`timescale 1ns/1ps
`include "ctrl_board_defines.svh"

module control_board #(
    parameter int CLKS_PER_MS = `CB_CLKS_PER_MS,
    parameter int RUN_HALF_MS = `CB_RUN_HALF_MS
)
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // DSP local bus
    input  ctrl_board_pkg::lbs_addr_t   lbs_addr_i,
    input  ctrl_board_pkg::lbs_data_t   lbs_din_i,
    input  logic                        lbs_cs_n_i,
    input  logic                        lbs_we_i,
    input  logic                        lbs_re_i,
    output ctrl_board_pkg::lbs_data_t   lbs_dout_o,
    output logic [7:0]                  dsp_fpga_d_o,   // Interrupt lines to DSP
    // Board I/O
    output logic [3:0]                  f_relay_con_o,
    output logic                        f_relay_oen_o,  // Active low
    input  logic [5:0]                  f_ttl_i,
    output logic [5:0]                  f_ttl_o,
    output logic                        f_ttl_en_o,
    input  logic [7:0]                  lvttl_i,
    output logic                        lvttl_en_o,
    output logic                        fpga_run_s_o,
    output logic                        speak_con_o
);

ctrl_board_pkg::reg_req_t   reg_req;
ctrl_board_pkg::reg_data_t  reg_rdata;
ctrl_board_pkg::pwm_cfg_t   pwm_cfg;

lbs_ctrl u_lbs_ctrl
(
    .clk_i              (clk_i          ),
    .rst_n_i            (rst_n_i        ),
    .lbs_addr_i         (lbs_addr_i     ),
    .lbs_din_i          (lbs_din_i      ),
    .lbs_cs_n_i         (lbs_cs_n_i     ),
    .lbs_we_i           (lbs_we_i       ),
    .lbs_re_i           (lbs_re_i       ),
    .rdata_i            (reg_rdata      ),
    .req_o              (reg_req        ),
    .lbs_dout_o         (lbs_dout_o     )
);

sys_registers u_sys_registers
(
    .clk_i              (clk_i          ),
    .rst_n_i            (rst_n_i        ),
    .req_i              (reg_req        ),
    .f_ttl_i            (f_ttl_i        ),
    .lvttl_i            (lvttl_i        ),
    .rdata_o            (reg_rdata      ),
    .int_o              (dsp_fpga_d_o   ),
    .relay_con_o        (f_relay_con_o  ),
    .relay_oen_o        (f_relay_oen_o  ),
    .ttl_o              (f_ttl_o        ),
    .ttl_en_o           (f_ttl_en_o     ),
    .lvttl_en_o         (lvttl_en_o     ),
    .pwm_cfg_o          (pwm_cfg        )
);

board_timer #(
    .CLKS_PER_MS        (CLKS_PER_MS    ),
    .RUN_HALF_MS        (RUN_HALF_MS    )
)
u_board_timer
(
    .clk_i              (clk_i          ),
    .rst_n_i            (rst_n_i        ),
    .run_o              (fpga_run_s_o   )
);

pwm_ctrl u_pwm_ctrl
(
    .clk_i              (clk_i          ),
    .rst_n_i            (rst_n_i        ),
    .cfg_i              (pwm_cfg        ),
    .pwm_o              (speak_con_o    )
);

endmodule

// ==== verif/control_board_assertions.sv ====
// Samples on the rising board clock; the interrupt mask is taken from inside the register block
`timescale 1ns/1ps

module control_board_assertions
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  ctrl_board_pkg::reg_req_t    reg_req,
    input  ctrl_board_pkg::pwm_cfg_t    pwm_cfg,
    input  ctrl_board_pkg::reg_data_t   int_mask,
    input  ctrl_board_pkg::lbs_data_t   lbs_dout_o,
    input  logic [7:0]                  dsp_fpga_d_o,
    input  logic [3:0]                  f_relay_con_o,
    input  logic                        f_relay_oen_o,
    input  logic [5:0]                  f_ttl_o,
    input  logic                        f_ttl_en_o,
    input  logic                        lvttl_en_o,
    input  logic                        speak_con_o
);

// ****************************************
// Protocol and output checks
// ****************************************
speaker_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pwm_cfg.en |-> !speak_con_o)
    else $error("speaker active while PWM disabled");

one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(reg_req.wr && reg_req.rd))
    else $error("register write and read requested together");

int_in_mask: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dsp_fpga_d_o & ~int_mask) == '0)
    else $error("interrupt line set outside the mask");

// Sync reset lands one edge later
reset_values: assert property (@(posedge clk_i)
    !rst_n_i |=> (lbs_dout_o == '0 && dsp_fpga_d_o == '0 && f_relay_con_o == '0
                  && f_relay_oen_o && f_ttl_o == '0 && !f_ttl_en_o && !lvttl_en_o
                  && !speak_con_o))
    else $error("output not at reset value during reset");

endmodule

bind control_board control_board_assertions u_assertions
(
    .clk_i          (clk_i                      ),
    .rst_n_i        (rst_n_i                    ),
    .reg_req        (reg_req                    ),
    .pwm_cfg        (pwm_cfg                    ),
    .int_mask       (u_sys_registers.int_mask_q ),
    .lbs_dout_o     (lbs_dout_o                 ),
    .dsp_fpga_d_o   (dsp_fpga_d_o               ),
    .f_relay_con_o  (f_relay_con_o              ),
    .f_relay_oen_o  (f_relay_oen_o              ),
    .f_ttl_o        (f_ttl_o                    ),
    .f_ttl_en_o     (f_ttl_en_o                 ),
    .lvttl_en_o     (lvttl_en_o                 ),
    .speak_con_o    (speak_con_o                )
);

// ==== verif/control_board_tb.sv ====
// Directed tests assume CLKS_PER_MS=4 and RUN_HALF_MS=3; every bus access holds its strobes 6 cycles
`timescale 1ns/1ps
`include "ctrl_board_defines.svh"

module control_board_tb;

localparam int CLKS_PER_MS = 4;
localparam int RUN_HALF_MS = 3;
localparam int RUN_PERIOD  = CLKS_PER_MS * RUN_HALF_MS;    // Clocks between run toggles
localparam int WAIT_LIMIT  = 200;

logic                       clk_i;
logic                       rst_n_i;
ctrl_board_pkg::lbs_addr_t  lbs_addr_i;
ctrl_board_pkg::lbs_data_t  lbs_din_i;
logic                       lbs_cs_n_i;
logic                       lbs_we_i;
logic                       lbs_re_i;
ctrl_board_pkg::lbs_data_t  lbs_dout_o;
logic [7:0]                 dsp_fpga_d_o;
logic [3:0]                 f_relay_con_o;
logic                       f_relay_oen_o;
logic [5:0]                 f_ttl_i;
logic [5:0]                 f_ttl_o;
logic                       f_ttl_en_o;
logic [7:0]                 lvttl_i;
logic                       lvttl_en_o;
logic                       fpga_run_s_o;
logic                       speak_con_o;

int                         err_count;
int                         test_count;
logic [31:0]                lfsr_q;

control_board #(
    .CLKS_PER_MS    (CLKS_PER_MS),
    .RUN_HALF_MS    (RUN_HALF_MS)
)
i_control_board (.*);

initial
begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;     // 125 MHz
end

// ****************************************
// Helpers
// ****************************************
task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected)
    begin
        $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        err_count++;
    end
endtask

task automatic report_test(input string name, input int start_err);
    test_count++;
    if (err_count == start_err)
        $display("Test %s: ok", name);
    else
        $display("Test %s: %0d errors", name, err_count - start_err);
endtask

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // Taps 32, 22, 2, 1
endfunction

task automatic random_byte(output ctrl_board_pkg::reg_data_t b);
    for (int i = 0; i < 8; i++)
    begin
        lfsr_q = lfsr_step(lfsr_q);
        b[i]   = lfsr_q[0];
    end
endtask

function automatic ctrl_board_pkg::lbs_addr_t reg_addr(input ctrl_board_pkg::reg_addr_t a);
    return `CB_REG_BASE | {4'h0, a};
endfunction

// ****************************************
// DSP local bus
// ****************************************
task automatic bus_write(input ctrl_board_pkg::lbs_addr_t addr,
                         input ctrl_board_pkg::reg_data_t data);
    @(posedge clk_i);
    lbs_addr_i <= addr;
    lbs_din_i  <= {8'h00, data};
    lbs_we_i   <= 1'b1;
    lbs_cs_n_i <= 1'b0;
    repeat (6) @(posedge clk_i);
    lbs_cs_n_i <= 1'b1;
    lbs_we_i   <= 1'b0;
    repeat (2) @(posedge clk_i);    // Chip select high gap
endtask

task automatic bus_read(input ctrl_board_pkg::lbs_addr_t addr,
                        output ctrl_board_pkg::lbs_data_t data);
    @(posedge clk_i);
    lbs_addr_i <= addr;
    lbs_re_i   <= 1'b1;
    lbs_cs_n_i <= 1'b0;
    repeat (6) @(posedge clk_i);
    lbs_cs_n_i <= 1'b1;
    lbs_re_i   <= 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    data = lbs_dout_o;
endtask

task automatic wait_int(input int idx, output logic seen);
    seen = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !seen; n++)
    begin
        @(negedge clk_i);
        seen = dsp_fpga_d_o[idx];
    end
endtask

// Caller sits on a falling edge
task automatic wait_run_toggle(output int cycles, output logic seen);
    logic start;
    start  = fpga_run_s_o;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < WAIT_LIMIT)
    begin
        @(negedge clk_i);
        cycles++;
        seen = (fpga_run_s_o !== start);
    end
endtask

// ****************************************
// Directed tests
// ****************************************
task automatic test_reset();
    int                         start_err;
    ctrl_board_pkg::lbs_data_t  rd;
    start_err = err_count;
    @(negedge clk_i);
    check("reset dout", 0, lbs_dout_o);
    check("reset int", 0, dsp_fpga_d_o);
    check("reset relay", 5'b10000, {f_relay_oen_o, f_relay_con_o});
    check("reset ttl", 0, {f_ttl_en_o, lvttl_en_o, f_ttl_o});
    check("reset speaker", 0, speak_con_o);
    bus_read(reg_addr(`CB_ADDR_VERSION), rd);
    check("reset version", 16'h0017, rd);
    bus_read(12'h100, rd);                  // Just above the register window
    check("reset outside window", 0, rd);
    report_test("reset", start_err);
endtask

task automatic test_rw();
    int                         start_err;
    ctrl_board_pkg::reg_data_t  d;
    ctrl_board_pkg::lbs_data_t  rd;
    start_err = err_count;
    repeat (2)
    begin
        random_byte(d);
        bus_write(reg_addr(`CB_ADDR_SCRATCH), d);
        bus_read(reg_addr(`CB_ADDR_SCRATCH), rd);
        check("rw scratch", d, rd);
        random_byte(d);
        bus_write(reg_addr(`CB_ADDR_RELAY), d);
        bus_read(reg_addr(`CB_ADDR_RELAY), rd);
        check("rw relay", {d[7], 3'b000, d[3:0]}, rd);
        check("rw relay pins", {d[7], d[3:0]}, {f_relay_oen_o, f_relay_con_o});
        random_byte(d);
        bus_write(reg_addr(`CB_ADDR_TTL_OUT), d);
        bus_read(reg_addr(`CB_ADDR_TTL_OUT), rd);
        check("rw ttl_out", d, rd);
        check("rw ttl pins", d, {f_ttl_en_o, lvttl_en_o, f_ttl_o});
    end
    report_test("read/write", start_err);
endtask

task automatic test_inputs();
    int                         start_err;
    ctrl_board_pkg::reg_data_t  t;
    ctrl_board_pkg::reg_data_t  l;
    ctrl_board_pkg::lbs_data_t  rd;
    start_err = err_count;
    random_byte(t);
    random_byte(l);
    @(posedge clk_i);
    f_ttl_i <= t[5:0];
    lvttl_i <= l;
    bus_read(reg_addr(`CB_ADDR_TTL_IN), rd);
    check("inputs ttl", {2'b00, t[5:0]}, rd);
    bus_read(reg_addr(`CB_ADDR_LVTTL_IN), rd);
    check("inputs lvttl", l, rd);
    report_test("inputs", start_err);
endtask

task automatic test_interrupts();
    int                         start_err;
    logic                       seen;
    ctrl_board_pkg::lbs_data_t  rd;
    start_err = err_count;
    @(posedge clk_i);
    lvttl_i <= 8'h00;
    bus_write(reg_addr(`CB_ADDR_INT_STATUS), 8'hff);   // Drop edges from the input test
    bus_write(reg_addr(`CB_ADDR_INT_MASK), 8'h05);
    @(negedge clk_i);
    check("int idle", 0, dsp_fpga_d_o);
    @(posedge clk_i);
    lvttl_i <= 8'h03;                       // Bit 0 masked in, bit 1 masked out
    wait_int(0, seen);
    if (!seen)
    begin
        $display("Timeout: dsp_fpga_d_o bit 0 never rose after an LVTTL edge");
        err_count++;
    end
    check("int masked", 8'h01, dsp_fpga_d_o);
    bus_read(reg_addr(`CB_ADDR_INT_STATUS), rd);
    check("int status", 8'h03, rd);
    bus_write(reg_addr(`CB_ADDR_INT_STATUS), 8'h01);
    bus_read(reg_addr(`CB_ADDR_INT_STATUS), rd);
    check("int status cleared", 8'h02, rd);
    check("int output cleared", 0, dsp_fpga_d_o);
    report_test("interrupts", start_err);
endtask

task automatic test_pwm();
    int                         start_err;
    int                         highs;
    ctrl_board_pkg::phase_t     ftw;
    ctrl_board_pkg::phase_t     duty;
    start_err = err_count;
    ftw  = 32'h1000_0000;                   // 16-cycle period
    duty = 32'h8000_0000;                   // Half high
    for (int i = 0; i < 4; i++)
    begin
        bus_write(reg_addr(ctrl_board_pkg::reg_addr_t'(`CB_ADDR_FTW0 + i)), ftw[8*i +: 8]);
        bus_write(reg_addr(ctrl_board_pkg::reg_addr_t'(`CB_ADDR_DUTY0 + i)), duty[8*i +: 8]);
    end
    bus_write(reg_addr(`CB_ADDR_PWM_CTRL), 8'h03);     // Enable and load
    highs = 0;
    repeat (64)
    begin
        @(negedge clk_i);
        if (speak_con_o)
            highs++;
    end
    check("pwm high count", 32, highs);
    bus_write(reg_addr(`CB_ADDR_PWM_CTRL), 8'h00);
    highs = 0;
    repeat (32)
    begin
        @(negedge clk_i);
        if (speak_con_o)
            highs++;
    end
    check("pwm disabled", 0, highs);
    report_test("pwm", start_err);
endtask

task automatic test_run();
    int     start_err;
    int     cycles;
    logic   seen;
    start_err = err_count;
    @(negedge clk_i);
    wait_run_toggle(cycles, seen);          // Align to the first toggle
    if (seen)
        wait_run_toggle(cycles, seen);
    if (!seen)
    begin
        $display("Timeout: fpga_run_s_o did not toggle");
        err_count++;
    end
    else
        check("run interval", RUN_PERIOD, cycles);
    report_test("run indicator", start_err);
endtask

initial
begin
    rst_n_i    = 1'b0;
    lbs_addr_i = '0;
    lbs_din_i  = '0;
    lbs_cs_n_i = 1'b1;
    lbs_we_i   = 1'b0;
    lbs_re_i   = 1'b0;
    f_ttl_i    = '0;
    lvttl_i    = '0;
    err_count  = 0;
    test_count = 0;
    lfsr_q     = 32'haa7b;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset();
    test_rw();
    test_inputs();
    test_interrupts();
    test_pwm();
    test_run();
    $display("Tests run: %0d, failed checks: %0d", test_count, err_count);
    if (err_count == 0)
        $display("Testbench passed");
    else
        $display("Testbench failed");
    $finish;
end

endmodule

// ==== src.f ====
+incdir+common
common/ctrl_board_pkg.sv
hw/lbs_ctrl.sv
hw/sys_registers.sv
hw/board_timer.sv
hw/pwm_ctrl.sv
hw/control_board.sv
verif/control_board_assertions.sv
verif/control_board_tb.sv

// ==== Bender.yml ====
package:
  name: control_board

export_include_dirs:
  - common

sources:
  - files:
      - common/ctrl_board_pkg.sv
      - hw/lbs_ctrl.sv
      - hw/sys_registers.sv
      - hw/board_timer.sv
      - hw/pwm_ctrl.sv
      - hw/control_board.sv
  - target: test
    files:
      - verif/control_board_assertions.sv
      - verif/control_board_tb.sv
